// ==== Makefile ====
# Verilator simulation of the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_ctrl (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  req,
  input  dcache_pkg::cpu_req_t                  cpu_req,
  input  logic                                  hit,
  input  dcache_pkg::way_t                      hit_way,
  input  dcache_pkg::way_t                      victim_way,
  input  dcache_pkg::tag_entry_t [`DC_WAYS-1:0] tags,
  input  logic [`DC_WAYS-1:0][31:0]             word_rdata,
  input  logic                                  mover_done,
  output logic                                  mover_start,
  output logic [`DC_WAYS-1:0]                   tag_we,
  output dcache_pkg::tag_entry_t                tag_wdata,
  output logic [`DC_IDX_W-1:0]                  data_addr,
  output logic [`DC_WAYS-1:0]                   data_we,
  output logic [31:0]                           data_wdata,
  output logic                                  touch,
  output dcache_pkg::way_t                      touch_way,
  output logic [31:0]                           rdata,
  output logic                                  ok,
  output logic                                  miss
);

  import dcache_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_REFILL_WAIT,
    ST_TAG_WRITE,
    ST_RETRY
  } state_t;

  state_t              state;
  cpu_req_t            req_q;
  logic                lookup_hit;
  logic [31:0]         hit_word;
  logic [31:0]         merged;
  logic [`DC_WAYS-1:0] hit_onehot;
  logic [`DC_WAYS-1:0] victim_onehot;

  assign lookup_hit    = (state == ST_LOOKUP) && hit;
  assign hit_word      = word_rdata[hit_way];
  assign hit_onehot    = {{(`DC_WAYS - 1){1'b0}}, 1'b1} << hit_way;
  assign victim_onehot = {{(`DC_WAYS - 1){1'b0}}, 1'b1} << victim_way;

  always_comb
  begin
    for (int b = 0; b < 4; b++)
      merged[8*b +: 8] = req_q.be[b] ? req_q.wdata[8*b +: 8] : hit_word[8*b +: 8];
  end

  ////////////////////////////////////////////////////////////////////////////
  // RAM requests

  // Live address while idle, so the RAM read overlaps the req cycle
  assign data_addr  = (state == ST_IDLE) ? {cpu_req.addr.set, cpu_req.addr.word}
                                         : {req_q.addr.set, req_q.addr.word};
  assign data_wdata = merged;
  assign data_we    = (lookup_hit && req_q.write) ? hit_onehot : '0;

  always_comb
  begin
    tag_wdata.valid = 1'b1;
    tag_wdata.dirty = (state != ST_TAG_WRITE);  // Refilled lines start clean
    tag_wdata.tag   = req_q.addr.tag;
  end

  always_comb
  begin
    if (state == ST_TAG_WRITE)
      tag_we = victim_onehot;
    else if (lookup_hit && req_q.write && !tags[hit_way].dirty)
      tag_we = hit_onehot;
    else
      tag_we = '0;
  end

  assign mover_start = (state == ST_LOOKUP) && !hit;
  assign touch       = lookup_hit;
  assign touch_way   = hit_way;

  ////////////////////////////////////////////////////////////////////////////
  // Request FSM

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= ST_IDLE;
      ok    <= 1'b0;
      miss  <= 1'b0;
    end
    else
    begin
      ok <= 1'b0;
      case (state)
        ST_IDLE:
          if (req)
            state <= ST_LOOKUP;
        ST_LOOKUP:
          if (hit)
          begin
            ok    <= 1'b1;
            miss  <= 1'b0;
            state <= ST_IDLE;
          end
          else
          begin
            miss  <= 1'b1;
            state <= ST_REFILL_WAIT;
          end
        ST_REFILL_WAIT:
          if (mover_done)
            state <= ST_TAG_WRITE;
        ST_TAG_WRITE: state <= ST_RETRY;
        ST_RETRY:     state <= ST_LOOKUP;  // Re-read tags after the write lands
        default:      state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE && req)
      req_q <= cpu_req;
    if (lookup_hit)
      rdata <= req_q.write ? merged : hit_word;
  end

endmodule

`default_nettype wire

// ==== design/dcache_defines.svh ====
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Cache geometry
`define DC_WAYS   4
`define DC_SETS   16
`define DC_WORDS  16

// Address split, tag | set | word | byte
`define DC_SET_W  4
`define DC_WORD_W 4
`define DC_BYTE_W 2
`define DC_TAG_W  22

// Data RAM index is set and word together
`define DC_IDX_W  (`DC_SET_W + `DC_WORD_W)

`endif

// ==== design/dcache_line_mover.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_line_mover (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic                  dirty,
  input  logic [`DC_TAG_W-1:0]  victim_tag,
  input  logic [`DC_SET_W-1:0]  set,
  input  logic [`DC_TAG_W-1:0]  fill_tag,
  output dcache_pkg::mem_rd_t   mem_rd,
  output dcache_pkg::mem_wr_t   mem_wr,
  input  logic                  rd_ok,
  input  logic [31:0]           rd_data,
  input  logic                  wr_ok,
  output logic [`DC_IDX_W-1:0]  ram_addr,
  output logic                  ram_we,
  output logic [31:0]           ram_wdata,
  input  logic [31:0]           ram_rdata,
  output logic                  busy,
  output logic                  done
);

  import dcache_pkg::*;

  typedef enum logic [1:0] {MV_IDLE, MV_WB, MV_FILL} mv_state_t;

  mv_state_t              state;
  logic [`DC_WORD_W-1:0]  cnt;
  logic [`DC_WORD_W-1:0]  cnt_next;
  logic                   last;
  logic [`DC_SET_W-1:0]   set_q;
  logic [`DC_TAG_W-1:0]   wb_tag_q;
  logic [`DC_TAG_W-1:0]   fill_tag_q;

  assign last     = &cnt;
  assign cnt_next = wr_ok ? cnt + 1'b1 : cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Burst sequencing

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= MV_IDLE;
      cnt   <= '0;
      done  <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        MV_IDLE:
          if (start)
          begin
            cnt   <= '0;
            state <= dirty ? MV_WB : MV_FILL;
          end
        MV_WB:
          if (wr_ok)
          begin
            cnt <= cnt + 1'b1;   // Wraps to 0 for the refill
            if (last)
              state <= MV_FILL;
          end
        MV_FILL:
          if (rd_ok)
          begin
            cnt <= cnt + 1'b1;
            if (last)
            begin
              state <= MV_IDLE;
              done  <= 1'b1;
            end
          end
        default: state <= MV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == MV_IDLE && start)
    begin
      set_q      <= set;
      wb_tag_q   <= victim_tag;
      fill_tag_q <= fill_tag;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // RAM and memory ports

  // Word 0 is fetched in the start cycle so write-back data is ready at once
  always_comb
  begin
    case (state)
      MV_WB:   ram_addr = {set_q, cnt_next};
      MV_FILL: ram_addr = {set_q, cnt};
      default: ram_addr = {set, {`DC_WORD_W{1'b0}}};
    endcase
  end

  assign ram_we    = (state == MV_FILL) && rd_ok;
  assign ram_wdata = rd_data;
  assign busy      = (state != MV_IDLE) || start;

  assign mem_wr.en   = (state == MV_WB);
  assign mem_wr.addr = {wb_tag_q, set_q, {(`DC_WORD_W + `DC_BYTE_W){1'b0}}};
  assign mem_wr.data = ram_rdata;

  assign mem_rd.en   = (state == MV_FILL);
  assign mem_rd.addr = {fill_tag_q, set_q, {(`DC_WORD_W + `DC_BYTE_W){1'b0}}};

endmodule

`default_nettype wire

// ==== design/dcache_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_lookup (
  input  logic                                  clk,
  input  logic                                  rst,
  input  dcache_pkg::tag_entry_t [`DC_WAYS-1:0] tags,
  input  logic [`DC_TAG_W-1:0]                  req_tag,
  input  logic [`DC_SET_W-1:0]                  set,
  input  logic                                  touch,
  input  dcache_pkg::way_t                      touch_way,
  output logic                                  hit,
  output dcache_pkg::way_t                      hit_way,
  output dcache_pkg::way_t                      victim_way
);

  import dcache_pkg::*;

  logic [`DC_WAYS-1:0][1:0] age [`DC_SETS];
  logic [`DC_WAYS-1:0][1:0] set_age;
  logic [`DC_WAYS-1:0]      match;
  logic                     have_free;

  assign set_age = age[set];

  always_comb
  begin
    hit_way = '0;
    for (int w = `DC_WAYS - 1; w >= 0; w--)
    begin
      match[w] = tags[w].valid && (tags[w].tag == req_tag);
      if (match[w])
        hit_way = way_t'(w);
    end
  end

  assign hit = |match;

  // Free way first, else the oldest one
  always_comb
  begin
    victim_way = '0;
    have_free  = 1'b0;
    for (int w = `DC_WAYS - 1; w >= 0; w--)
    begin
      if (!tags[w].valid)
      begin
        victim_way = way_t'(w);
        have_free  = 1'b1;
      end
    end
    if (!have_free)
    begin
      for (int w = 1; w < `DC_WAYS; w++)
        if (set_age[w] > set_age[victim_way])  // Strict, low index wins ties
          victim_way = way_t'(w);
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      age <= '{default: '0};
    else if (touch)
    begin
      for (int w = 0; w < `DC_WAYS; w++)
      begin
        if (way_t'(w) == touch_way)
          age[set][w] <= 2'd0;
        else if (set_age[w] <= set_age[touch_way])
          age[set][w] <= set_age[w] + 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/dcache_pkg.sv ====
`default_nettype none

`include "dcache_defines.svh"

package dcache_pkg;

  typedef struct packed {
    logic [`DC_TAG_W-1:0]  tag;
    logic [`DC_SET_W-1:0]  set;
    logic [`DC_WORD_W-1:0] word;
    logic [`DC_BYTE_W-1:0] byte_off;
  } addr_t;

  typedef struct packed {
    addr_t       addr;
    logic [31:0] wdata;
    logic [3:0]  be;     // One bit per byte lane
    logic        write;
  } cpu_req_t;

  typedef struct packed {
    logic                 valid;
    logic                 dirty;
    logic [`DC_TAG_W-1:0] tag;
  } tag_entry_t;

  typedef struct packed {
    logic        en;
    logic [31:0] addr;   // Line aligned
  } mem_rd_t;

  typedef struct packed {
    logic        en;
    logic [31:0] addr;
    logic [31:0] data;
  } mem_wr_t;

  typedef logic [1:0] way_t;

endpackage

`default_nettype wire

// ==== design/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req,
  input  dcache_pkg::cpu_req_t cpu_req,
  output logic [31:0]          rdata,
  output logic                 ok,
  output logic                 miss,
  output dcache_pkg::mem_rd_t  mem_rd,
  output dcache_pkg::mem_wr_t  mem_wr,
  input  logic                 rd_ok,
  input  logic [31:0]          rd_data,
  input  logic                 wr_ok
);

  import dcache_pkg::*;

  tag_entry_t [`DC_WAYS-1:0]  tags;
  logic [`DC_WAYS-1:0][31:0]  words;
  logic [`DC_WAYS-1:0]        tag_we;
  tag_entry_t                 tag_wdata;
  logic [`DC_SET_W-1:0]       cur_set;

  logic                       hit;
  way_t                       hit_way;
  way_t                       victim_way;
  logic                       touch;
  way_t                       touch_way;

  logic [`DC_IDX_W-1:0]       ctrl_addr;
  logic [`DC_WAYS-1:0]        ctrl_we;
  logic [31:0]                ctrl_wdata;
  logic                       mv_start;
  logic                       mv_done;
  logic                       mv_busy;
  logic [`DC_IDX_W-1:0]       mv_addr;
  logic                       mv_we;
  logic [31:0]                mv_wdata;

  logic [`DC_IDX_W-1:0]       ram_addr;
  logic [`DC_WAYS-1:0]        ram_we;
  logic [31:0]                ram_wdata;

  assign cur_set = ctrl_addr[`DC_WORD_W +: `DC_SET_W];

  // Mover owns the data RAMs for a whole burst, victim way only
  assign ram_addr  = mv_busy ? mv_addr : ctrl_addr;
  assign ram_wdata = mv_busy ? mv_wdata : ctrl_wdata;
  assign ram_we    = mv_busy ? ({{(`DC_WAYS - 1){1'b0}}, mv_we} << victim_way) : ctrl_we;

  for (genvar w = 0; w < `DC_WAYS; w++)
  begin : g_way
    dcache_way_ram #(.payload_t(tag_entry_t), .DEPTH(`DC_SETS)) u_tag (
      .clk(clk), .rst(rst), .addr(cur_set), .we(tag_we[w]),
      .wdata(tag_wdata), .rdata(tags[w])
    );
    dcache_way_ram #(.payload_t(logic [31:0]), .DEPTH(`DC_SETS * `DC_WORDS)) u_data (
      .clk(clk), .rst(rst), .addr(ram_addr), .we(ram_we[w]),
      .wdata(ram_wdata), .rdata(words[w])
    );
  end

  dcache_lookup u_lookup (
    .clk(clk), .rst(rst), .tags(tags), .req_tag(tag_wdata.tag), .set(cur_set),
    .touch(touch), .touch_way(touch_way),
    .hit(hit), .hit_way(hit_way), .victim_way(victim_way)
  );

  // Victim way holds still during a burst, no tag or age updates then
  dcache_line_mover u_mover (
    .clk(clk), .rst(rst), .start(mv_start),
    .dirty(tags[victim_way].dirty), .victim_tag(tags[victim_way].tag),
    .set(cur_set), .fill_tag(tag_wdata.tag),
    .mem_rd(mem_rd), .mem_wr(mem_wr),
    .rd_ok(rd_ok), .rd_data(rd_data), .wr_ok(wr_ok),
    .ram_addr(mv_addr), .ram_we(mv_we), .ram_wdata(mv_wdata),
    .ram_rdata(words[victim_way]), .busy(mv_busy), .done(mv_done)
  );

  dcache_ctrl u_ctrl (
    .clk(clk), .rst(rst), .req(req), .cpu_req(cpu_req),
    .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
    .tags(tags), .word_rdata(words), .mover_done(mv_done), .mover_start(mv_start),
    .tag_we(tag_we), .tag_wdata(tag_wdata),
    .data_addr(ctrl_addr), .data_we(ctrl_we), .data_wdata(ctrl_wdata),
    .touch(touch), .touch_way(touch_way),
    .rdata(rdata), .ok(ok), .miss(miss)
  );

endmodule

`default_nettype wire

// ==== design/dcache_way_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_way_ram #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 16
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  logic                     we,
  input  payload_t                 wdata,
  output payload_t                 rdata
);

  payload_t mem [DEPTH];

  // Read first, so a write returns the old entry on the same edge
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < DEPTH; i++)
        mem[i] <= '0;  // Tag entries come back invalid
      rdata <= '0;
    end
    else
    begin
      if (we)
        mem[addr] <= wdata;
      rdata <= mem[addr];
    end
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+design
design/dcache_pkg.sv
design/dcache_way_ram.sv
design/dcache_lookup.sv
design/dcache_line_mover.sv
design/dcache_ctrl.sv
design/dcache_top.sv
test/dcache_chk.sv
test/dcache_tb.sv

// ==== test/dcache_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_chk (
  input logic                clk,
  input logic                rst,
  input logic                ok,
  input logic                miss,
  input dcache_pkg::mem_rd_t mem_rd,
  input dcache_pkg::mem_wr_t mem_wr
);

  int unsigned errors = 0;  // Summed into the testbench totals

  a_ok_pulse: assert property (@(posedge clk) disable iff (rst) ok |=> !ok)
  else
  begin
    $error("ok stayed high for more than one cycle");
    errors++;
  end

  a_mem_excl: assert property (@(posedge clk) !(mem_rd.en && mem_wr.en))
  else
  begin
    $error("memory read and write enables high together");
    errors++;
  end

  // Quiet outputs once reset has been seen for a full cycle
  a_reset_quiet: assert property (@(posedge clk)
    rst && $past(rst) |-> !ok && !mem_rd.en && !mem_wr.en)
  else
  begin
    $error("ok or a memory enable active during reset");
    errors++;
  end

  a_ok_no_miss: assert property (@(posedge clk) disable iff (rst) ok |-> !miss)
  else
  begin
    $error("ok pulsed while miss was still high");
    errors++;
  end

  a_miss_ends: assert property (@(posedge clk) disable iff (rst) $fell(miss) |-> ok)
  else
  begin
    $error("miss fell without an ok pulse");
    errors++;
  end

endmodule

`default_nettype wire

// ==== test/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_tb;

  import dcache_pkg::*;

  localparam int          OK_TIMEOUT = 400;  // Write-back plus refill, worst stalls
  localparam logic [31:0] MEM_SALT   = 32'hC3A5_5A3C;

  typedef struct {
    string       name;
    logic        write;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  be;
    logic        miss;
  } entry_t;

  logic        clk = 1'b0;
  logic        rst = 1'b0;
  logic        req = 1'b0;
  cpu_req_t    cpu_req = '0;
  logic [31:0] rdata;
  logic        ok;
  logic        miss;
  mem_rd_t     mem_rd;
  mem_wr_t     mem_wr;
  logic        rd_ok = 1'b0;
  logic [31:0] rd_data = '0;
  logic        wr_ok = 1'b0;

  entry_t      tests [$];
  logic [31:0] ref_mem [logic [29:0]];
  logic [31:0] mem_store [logic [29:0]];
  logic [31:0] wb_addr [$];
  logic [31:0] wb_data [$];
  logic [31:0] lfsr = 32'd83021;
  int          rd_idx = 0;
  int          wr_idx = 0;
  int          rd_stall = 0;
  int          wr_stall = 0;

  // Cache shadow for hit and victim prediction
  bit                   m_valid [`DC_SETS][`DC_WAYS];
  bit                   m_dirty [`DC_SETS][`DC_WAYS];
  bit [`DC_TAG_W-1:0]   m_tag   [`DC_SETS][`DC_WAYS];
  bit [1:0]             m_age   [`DC_SETS][`DC_WAYS];

  dcache_top DUT (
    .clk(clk), .rst(rst), .req(req), .cpu_req(cpu_req),
    .rdata(rdata), .ok(ok), .miss(miss),
    .mem_rd(mem_rd), .mem_wr(mem_wr),
    .rd_ok(rd_ok), .rd_data(rd_data), .wr_ok(wr_ok)
  );

  bind dcache_top dcache_chk u_chk (
    .clk(clk), .rst(rst), .ok(ok), .miss(miss), .mem_rd(mem_rd), .mem_wr(mem_wr)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Memory and reference helpers

  function automatic logic [31:0] mem_pattern(input logic [31:0] a);
    return {2'b00, a[31:2]} ^ MEM_SALT;
  endfunction

  function automatic logic [31:0] ref_word(input logic [31:0] a);
    if (ref_mem.exists(a[31:2]))
      return ref_mem[a[31:2]];
    return mem_pattern(a);
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    if (mem_store.exists(a[31:2]))
      return mem_store[a[31:2]];
    return mem_pattern(a);
  endfunction

  function automatic logic lfsr_step();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b)
      lfsr = lfsr ^ 32'h8020_0003;
    return b;
  endfunction

  function automatic int stall_draw();
    logic [1:0] v;
    v[0] = lfsr_step();
    v[1] = lfsr_step();
    return int'(v);
  endfunction

  task automatic write_ref(input logic [31:0] a, input logic [31:0] d, input logic [3:0] be);
    logic [31:0] w;
    w = ref_word(a);
    for (int b = 0; b < 4; b++)
      if (be[b])
        w[8*b +: 8] = d[8*b +: 8];
    ref_mem[a[31:2]] = w;
  endtask

  // First invalid way, else oldest, then the age update on the accessed way
  task automatic predict(input logic [31:0] a, input logic write, output logic pmiss,
                         output logic pwb, output logic [31:0] pline);
    addr_t      f;
    int         s;
    int         w;
    logic       found;
    logic [1:0] acc;
    f     = a;
    s     = int'(f.set);
    pmiss = 1'b1;
    pwb   = 1'b0;
    pline = '0;
    w     = 0;
    found = 1'b0;
    for (int i = `DC_WAYS - 1; i >= 0; i--)
    begin
      if (m_valid[s][i] && m_tag[s][i] == f.tag)
      begin
        pmiss = 1'b0;
        w     = i;
      end
    end
    if (pmiss)
    begin
      for (int i = `DC_WAYS - 1; i >= 0; i--)
      begin
        if (!m_valid[s][i])
        begin
          w     = i;
          found = 1'b1;
        end
      end
      if (!found)
      begin
        w = 0;
        for (int i = 1; i < `DC_WAYS; i++)
          if (m_age[s][i] > m_age[s][w])
            w = i;
      end
      if (m_valid[s][w] && m_dirty[s][w])
      begin
        pwb   = 1'b1;
        pline = {m_tag[s][w], f.set, {(`DC_WORD_W + `DC_BYTE_W){1'b0}}};
      end
      m_valid[s][w] = 1'b1;
      m_tag[s][w]   = f.tag;
      m_dirty[s][w] = 1'b0;
    end
    if (write)
      m_dirty[s][w] = 1'b1;
    acc = m_age[s][w];
    for (int i = 0; i < `DC_WAYS; i++)
    begin
      if (i == w)
        m_age[s][i] = 2'd0;
      else if (m_age[s][i] <= acc)
        m_age[s][i] = m_age[s][i] + 2'd1;
    end
  endtask

  task automatic add_test(input string name, input logic write, input logic [31:0] addr,
                          input logic [31:0] data, input logic [3:0] be, input logic miss);
    entry_t e;
    e.name  = name;
    e.write = write;
    e.addr  = addr;
    e.data  = data;
    e.be    = be;
    e.miss  = miss;
    tests.push_back(e);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model, random stalls before every accepted word

  always @(negedge clk)
  begin
    logic [31:0] wa;
    rd_ok = 1'b0;
    wr_ok = 1'b0;
    if (mem_rd.en)
    begin
      if (rd_stall > 0)
        rd_stall--;
      else
      begin
        rd_ok    = 1'b1;
        rd_data  = mem_word(mem_rd.addr + 32'(4 * rd_idx));
        rd_idx++;
        rd_stall = stall_draw();
      end
    end
    else
      rd_idx = 0;
    if (mem_wr.en)
    begin
      if (wr_stall > 0)
        wr_stall--;
      else
      begin
        wr_ok = 1'b1;
        wa    = mem_wr.addr + 32'(4 * wr_idx);  // Current word of the burst
        wb_addr.push_back(wa);
        wb_data.push_back(mem_wr.data);
        mem_store[wa[31:2]] = mem_wr.data;
        wr_idx++;
        wr_stall = stall_draw();
      end
    end
    else
      wr_idx = 0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table and checking loop

  initial
  begin
    entry_t      e;
    logic        pmiss;
    logic        pwb;
    logic [31:0] pline;
    logic [31:0] exp_data;
    logic        saw_miss;
    logic        timed_out;
    int          lat;
    int          terr;
    int          passed;
    int          failed;
    passed    = 0;
    failed    = 0;
    timed_out = 1'b0;

    // Set 3, tag 1 line then four more tags into the same set
    add_test("cold_rd",      1'b0, 32'h0000_04C8, 32'h0,         4'h0,    1'b1);
    add_test("reread_hit",   1'b0, 32'h0000_04C8, 32'h0,         4'h0,    1'b0);
    add_test("same_line_rd", 1'b0, 32'h0000_04DC, 32'h0,         4'h0,    1'b0);
    add_test("byte_wr",      1'b1, 32'h0000_04C8, 32'hA1B2_C3D4, 4'b0101, 1'b0);
    add_test("merged_rd",    1'b0, 32'h0000_04C8, 32'h0,         4'h0,    1'b0);
    add_test("word_wr",      1'b1, 32'h0000_04D4, 32'h1234_5678, 4'b1111, 1'b0);
    add_test("fill_tag2",    1'b0, 32'h0000_08C0, 32'h0,         4'h0,    1'b1);
    add_test("fill_tag3",    1'b0, 32'h0000_0CC0, 32'h0,         4'h0,    1'b1);
    add_test("fill_tag4",    1'b0, 32'h0000_10C4, 32'h0,         4'h0,    1'b1);
    add_test("evict_dirty",  1'b0, 32'h0000_14C0, 32'h0,         4'h0,    1'b1);
    add_test("reload_dirty", 1'b0, 32'h0000_04C8, 32'h0,         4'h0,    1'b1);
    add_test("reload_word",  1'b0, 32'h0000_04D4, 32'h0,         4'h0,    1'b0);
    // Set 5, ages steered so the second way is the oldest
    add_test("fill_a",       1'b0, 32'h0000_2140, 32'h0,         4'h0,    1'b1);
    add_test("fill_b",       1'b0, 32'h0000_2544, 32'h0,         4'h0,    1'b1);
    add_test("fill_c",       1'b0, 32'h0000_2948, 32'h0,         4'h0,    1'b1);
    add_test("fill_d",       1'b0, 32'h0000_2D4C, 32'h0,         4'h0,    1'b1);
    add_test("touch_a",      1'b0, 32'h0000_2140, 32'h0,         4'h0,    1'b0);
    add_test("touch_c",      1'b0, 32'h0000_2948, 32'h0,         4'h0,    1'b0);
    add_test("touch_a2",     1'b0, 32'h0000_2150, 32'h0,         4'h0,    1'b0);
    add_test("wr_miss_e",    1'b1, 32'h0000_3140, 32'hDEAD_BEEF, 4'b1100, 1'b1);
    add_test("reread_a",     1'b0, 32'h0000_2140, 32'h0,         4'h0,    1'b0);
    add_test("reread_c",     1'b0, 32'h0000_2948, 32'h0,         4'h0,    1'b0);
    add_test("reread_b",     1'b0, 32'h0000_2544, 32'h0,         4'h0,    1'b1);

    rst = 1'b1;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    for (int i = 0; i < tests.size() && !timed_out; i++)
    begin
      e    = tests[i];
      terr = 0;
      predict(e.addr, e.write, pmiss, pwb, pline);
      if (e.write)
        write_ref(e.addr, e.data, e.be);
      exp_data = ref_word(e.addr);
      wb_addr.delete();
      wb_data.delete();

      req           = 1'b1;
      cpu_req.addr  = e.addr;
      cpu_req.wdata = e.data;
      cpu_req.be    = e.be;
      cpu_req.write = e.write;
      lat      = 0;
      saw_miss = 1'b0;
      do
      begin
        @(negedge clk);
        req = 1'b0;
        lat++;
        if (miss)
          saw_miss = 1'b1;
      end
      while (!ok && lat < OK_TIMEOUT);

      assert (ok)
      else
      begin
        $display("%s: the cache gave no ok within %0d cycles", e.name, OK_TIMEOUT);
        timed_out = 1'b1;
        terr++;
      end
      if (ok)
      begin
        assert (pmiss == e.miss)
        else
        begin
          $display("%s: the table entry disagrees with the age model", e.name);
          terr++;
        end
        assert (saw_miss == e.miss)
        else
        begin
          $display("[ERROR] %s miss: expected %0b actual %0b", e.name, e.miss, saw_miss);
          terr++;
        end
        if (!e.miss)
        begin
          assert (lat == 2)
          else
          begin
            $display("[ERROR] %s latency: expected 2 actual %0d", e.name, lat);
            terr++;
          end
        end
        assert (rdata == exp_data)
        else
        begin
          $display("[ERROR] %s rdata: expected %h actual %h", e.name, exp_data, rdata);
          terr++;
        end
        assert (wb_addr.size() == (pwb ? 16 : 0))
        else
        begin
          $display("[ERROR] %s write-back words: expected %0d actual %0d",
                   e.name, pwb ? 16 : 0, wb_addr.size());
          terr++;
        end
        for (int k = 0; k < wb_addr.size(); k++)
        begin
          assert (wb_addr[k] == pline + 32'(4 * k))
          else
          begin
            $display("[ERROR] %s wb addr %0d: expected %h actual %h",
                     e.name, k, pline + 32'(4 * k), wb_addr[k]);
            terr++;
          end
          assert (wb_data[k] == ref_word(wb_addr[k]))
          else
          begin
            $display("[ERROR] %s wb data %0d: expected %h actual %h",
                     e.name, k, ref_word(wb_addr[k]), wb_data[k]);
            terr++;
          end
        end
      end

      if (terr == 0)
        passed++;
      else
        failed++;
      $display("%-14s %s", e.name, (terr == 0) ? "pass" : "fail");
    end

    $display("%0d tests: %0d passed, %0d failed, %0d assertion errors",
             tests.size(), passed, failed, DUT.u_chk.errors);
    if (failed == 0 && !timed_out && DUT.u_chk.errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
